/* verilog.f */
fetch_pkg.sv
pc_gen.sv
line_fetch.sv
mc_seq.sv
pipe_mux.sv
fetch_top.sv
fetch_checker.sv
tb_clkgen.sv
tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_front

sources:
  - fetch_pkg.sv
  - pc_gen.sv
  - line_fetch.sv
  - mc_seq.sv
  - pipe_mux.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_checker.sv
      - tb_clkgen.sv
      - tb_fetch_top.sv

/* tb_fetch_top.sv */
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

	localparam int period = 40;
	localparam int n_tests = 6;
	localparam int max_delay = 3; // Ack delay is two LFSR bits.
	localparam int burst_cycles = 16 * (max_delay + 2);
	localparam int test_cycles = 4 * burst_cycles + 120;
	localparam int src_line = 0;
	localparam int src_hwi = 1;
	localparam int src_mc = 2;

	logic clk;
	logic rst;
	logic redirect;
	logic [pc_w-1:0] redirect_pc;
	logic hwi;
	logic [insn_w-1:0] hwi_ins;
	logic mc_req;
	logic [7:0] mc_entry;
	logic decode_ready;
	logic wb_cyc;
	logic wb_stb;
	logic [adr_w-1:0] wb_adr;
	logic [insn_w-1:0] wb_dat = '0;
	logic wb_ack = 1'b0;
	logic [line_w-1:0] cline;
	logic [slots-1:0] pr_valid;
	logic [slots-1:0][pc_w-1:0] pr_pc;
	logic [slots-1:0][insn_w-1:0] pr_ins;

	int errors = 0;
	int checks = 0;
	int n_done = 0;
	int n_line = 0;
	int n_hwi = 0;
	int n_mc = 0;
	logic [pc_w-1:0] line_pc_q;
	logic [slots-1:0] line_valid_q;
	logic [pc_w-1:0] hwi_pc_q;
	logic [pc_w-1:0] mc_pc_q;

	tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

	fetch_top dut_i (
		.clk            (clk),
		.rst            (rst),
		.redirect_i     (redirect),
		.redirect_pc_i  (redirect_pc),
		.hwi_i          (hwi),
		.hwi_ins_i      (hwi_ins),
		.mc_req_i       (mc_req),
		.mc_entry_i     (mc_entry),
		.decode_ready_i (decode_ready),
		.wb_cyc_o       (wb_cyc),
		.wb_stb_o       (wb_stb),
		.wb_adr_o       (wb_adr),
		.wb_dat_i       (wb_dat),
		.wb_ack_i       (wb_ack),
		.cline_o        (cline),
		.pr_valid_o     (pr_valid),
		.pr_pc_o        (pr_pc),
		.pr_ins_o       (pr_ins)
	);

	// ####################
	// Helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	function automatic int lfsr_bits(inout logic [31:0] s, input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			s = lfsr_next(s);
			r = (r << 1) | int'(s[0]);
		end
		return r;
	endfunction

	// Memory content depends on every bit of the word address.
	function automatic logic [insn_w-1:0] mem_word(input logic [adr_w-1:0] adr);
		return {adr[7:0], ~adr[15:8], adr[29:16] ^ 14'h2a5c, 2'b10};
	endfunction

	// Slots left before the end of the 64-byte line.
	function automatic int line_slots(input logic [pc_w-1:0] pc);
		int n;
		n = (64 - int'(pc[5:0])) / 4;
		return (n > slots) ? slots : n;
	endfunction

	function automatic void ref_bundle(
		input int src,
		input logic [pc_w-1:0] pc,
		input logic [insn_w-1:0] aux,
		output logic [slots-1:0] v,
		output logic [slots-1:0][pc_w-1:0] p,
		output logic [slots-1:0][insn_w-1:0] ins
	);
		v = '0;
		for (int i = 0; i < slots; i++) begin
			p[i] = pc + pc_w'(4 * i);
			ins[i] = {OP_NOP, 24'h00_0000};
			if (src == src_hwi && i == 0) begin
				v[i] = 1'b1;
				ins[i] = aux;
			end else if (src == src_mc && i < mc_slots) begin
				v[i] = 1'b1;
				ins[i] = {OP_MC, aux[15:8], aux[7:0], 8'(i)}; // Aux holds entry and step.
			end else if (src == src_line && i < line_slots(pc)) begin
				v[i] = 1'b1;
				ins[i] = mem_word(p[i][pc_w-1:2]);
			end
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error: %0s = %h, expected %h at time %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_bundle(input int src, input logic [pc_w-1:0] pc, input logic [31:0] aux);
		logic [slots-1:0] v;
		logic [slots-1:0][pc_w-1:0] p;
		logic [slots-1:0][insn_w-1:0] ins;
		ref_bundle(src, pc, aux, v, p, ins);
		check_value("pr_valid_o", 32'(pr_valid), 32'(v));
		for (int i = 0; i < slots; i++) begin
			check_value($sformatf("pr_pc_o[%0d]", i), pr_pc[i], p[i]);
			check_value($sformatf("pr_ins_o[%0d]", i), pr_ins[i], ins[i]);
		end
	endtask

	task automatic check_line(input logic [pc_w-1:0] pc);
		logic [adr_w-1:0] adr;
		for (int j = 0; j < 16; j++) begin
			adr = {pc[pc_w-1:6], 4'(j)};
			check_value($sformatf("cline_o[%0d]", j),
				cline[j*insn_w +: insn_w], mem_word(adr)); // Word 0 in bits 31:0.
		end
	endtask

	task automatic wait_bundles(input int src, input int target);
		while ((src == src_line ? n_line : (src == src_hwi ? n_hwi : n_mc)) < target) begin
			@(negedge clk);
		end
	endtask

	task automatic finish_test(input string name, input int err_base);
		n_done++;
		$display("test %0s finished with %0d errors", name, errors - err_base);
	endtask

	// ####################
	// Memory model

	logic [31:0] mem_lfsr = 32'hc7e1_d501;
	int delay = 0;

	always @(negedge clk) begin
		if (rst || wb_ack) begin
			wb_ack = 1'b0;
			delay = lfsr_bits(mem_lfsr, 2);
		end else if (wb_cyc && wb_stb) begin
			if (delay == 0) begin
				wb_ack = 1'b1;
				wb_dat = mem_word(wb_adr);
			end else begin
				delay--;
			end
		end
	end

	// ####################
	// Compare

	// Outputs read here still show the previous edge, with the inputs it sampled.
	logic prev_rst = 1'b1;
	logic prev_ready = 1'b0;
	logic prev_hwi = 1'b0;
	logic [insn_w-1:0] prev_hwi_ins = '0;
	logic prev_mc_req = 1'b0;
	logic [7:0] prev_mc_entry = '0;
	logic prev_redirect = 1'b0;
	logic [pc_w-1:0] prev_redirect_pc = '0;
	logic [slots-1:0] last_valid;
	logic [slots-1:0][pc_w-1:0] last_pc;
	logic [slots-1:0][insn_w-1:0] last_ins;
	logic [pc_w-1:0] model_pc = '0;
	logic mc_run = 1'b0;
	logic mc_was_run;
	logic [7:0] mc_entry_q = '0;
	int mc_step = 0;
	logic changed;

	always @(posedge clk) begin
		changed = (pr_valid !== last_valid) || (pr_pc !== last_pc) || (pr_ins !== last_ins);
		mc_was_run = mc_run;
		if (prev_rst) begin
			model_pc = '0;
			mc_run = 1'b0;
		end else if (prev_ready && prev_hwi) begin
			check_bundle(src_hwi, model_pc, prev_hwi_ins);
			hwi_pc_q = model_pc;
			n_hwi++;
		end else if (prev_ready && mc_run) begin
			check_bundle(src_mc, model_pc, {16'h0000, mc_entry_q, 8'(mc_step)});
			mc_pc_q = model_pc;
			mc_step++;
			if (mc_step == mc_len) begin
				mc_run = 1'b0;
			end
			n_mc++;
		end else if (prev_ready && changed) begin
			check_bundle(src_line, model_pc, '0);
			check_line(model_pc);
			line_pc_q = pr_pc[0];
			line_valid_q = pr_valid;
			model_pc = model_pc + pc_w'(4 * line_slots(model_pc));
			n_line++;
		end else begin
			checks++;
			assert (!changed) else begin
				$display("Bundle outputs changed at time %0t with no bundle accepted", $time);
				errors++;
			end
		end
		if (!prev_rst && !mc_was_run && prev_mc_req) begin
			mc_run = 1'b1;
			mc_step = 0;
			mc_entry_q = prev_mc_entry;
		end
		if (!prev_rst && prev_redirect) begin
			model_pc = prev_redirect_pc; // Wins over advance.
		end
		last_valid = pr_valid;
		last_pc = pr_pc;
		last_ins = pr_ins;
		prev_rst = rst;
		prev_ready = decode_ready;
		prev_hwi = hwi;
		prev_hwi_ins = hwi_ins;
		prev_mc_req = mc_req;
		prev_mc_entry = mc_entry;
		prev_redirect = redirect;
		prev_redirect_pc = redirect_pc;
	end

	// ####################
	// Stimulus

	logic [31:0] stim_lfsr = 32'hc7e1_d501;

	initial begin
		int err_base;
		int base;
		redirect = 1'b0;
		redirect_pc = '0;
		hwi = 1'b0;
		hwi_ins = '0;
		mc_req = 1'b0;
		mc_entry = '0;
		decode_ready = 1'b1;
		wait (rst === 1'b0); // Released on a falling edge.

		err_base = errors;
		check_value("pr_valid_o", 32'(pr_valid), 32'h0);
		check_value("wb_cyc_o", 32'(wb_cyc), 32'h0);
		finish_test("reset", err_base);

		err_base = errors;
		wait_bundles(src_line, 6);
		finish_test("sequential fetch", err_base);

		err_base = errors;
		@(negedge clk);
		decode_ready = 1'b0;
		redirect = 1'b1;
		redirect_pc = 32'h0000_0034;
		@(negedge clk);
		redirect = 1'b0;
		decode_ready = 1'b1;
		base = n_line;
		wait_bundles(src_line, base + 1);
		check_value("pr_pc_o[0]", line_pc_q, 32'h0000_0034);
		check_value("pr_valid_o", 32'(line_valid_q), 32'h0000_0007);
		wait_bundles(src_line, base + 2);
		check_value("pr_pc_o[0]", line_pc_q, 32'h0000_0040);
		finish_test("redirect", err_base);

		err_base = errors;
		wait_bundles(src_line, n_line + 1);
		hwi = 1'b1;
		hwi_ins = {OP_HWI, 24'h00_0042};
		base = n_hwi;
		@(negedge clk);
		hwi = 1'b0;
		wait_bundles(src_hwi, base + 1);
		wait_bundles(src_line, n_line + 1);
		check_value("pr_pc_o[0]", line_pc_q, hwi_pc_q); // Fetch PC held across the interrupt.
		finish_test("interrupt", err_base);

		err_base = errors;
		mc_req = 1'b1;
		mc_entry = 8'h2a;
		base = n_mc;
		@(negedge clk);
		mc_req = 1'b0;
		wait_bundles(src_mc, base + mc_len);
		wait_bundles(src_line, n_line + 1);
		check_value("pr_pc_o[0]", line_pc_q, mc_pc_q);
		finish_test("microcode", err_base);

		err_base = errors;
		for (int k = 0; k < 12; k++) begin
			decode_ready = 1'b0;
			repeat (lfsr_bits(stim_lfsr, 2) + 1) @(negedge clk);
			decode_ready = 1'b1;
			repeat (lfsr_bits(stim_lfsr, 2) + 1) @(negedge clk);
		end
		wait_bundles(src_line, n_line + 2);
		finish_test("back-pressure", err_base);

		errors = errors + dut_i.u_fetch_checker.fails;
		$display("%0d tests, %0d checks, %0d errors", n_done, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(n_tests * test_cycles * period);
		$display("Timeout: the tests did not finish in %0d cycles", n_tests * test_cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	localparam int half_period = 20;

	initial begin
		clk_o = 1'b0;
		forever #(half_period) clk_o = ~clk_o;
	end

	// Reset covers three rising edges and drops on a falling edge.
	initial begin
		rst_o = 1'b1;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

/* fetch_checker.sv */
`default_nettype none

module fetch_checker import fetch_pkg::*; (
	input wire               clk,
	input wire               rst,
	input wire               wb_cyc_i,
	input wire               wb_stb_i,
	input wire [adr_w-1:0]   wb_adr_i,
	input wire               wb_ack_i,
	input wire [slots-1:0]   pr_valid_i,
	input wire               mc_active_i
);

	int fails = 0; // Read by the testbench at the end of the run.

	// ####################
	// Wishbone classic

	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_i |-> wb_cyc_i)
		else begin $error("wb_stb_o is high outside a cycle"); fails++; end

	adr_held: assert property (@(posedge clk) disable iff (rst)
		wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
		else begin $error("wb_adr_o or wb_stb_o changed before ack"); fails++; end

	stb_gap: assert property (@(posedge clk) disable iff (rst) wb_stb_i && wb_ack_i |=> !wb_stb_i)
		else begin $error("wb_stb_o did not drop after ack"); fails++; end

	// ####################
	// Reset

	reset_state: assert property (@(posedge clk)
		rst |=> !wb_cyc_i && !wb_stb_i && pr_valid_i == '0 && !mc_active_i)
		else begin $error("state after reset is not idle"); fails++; end

endmodule

bind fetch_top fetch_checker u_fetch_checker (
	.clk         (clk),
	.rst         (rst),
	.wb_cyc_i    (wb_cyc_o),
	.wb_stb_i    (wb_stb_o),
	.wb_adr_i    (wb_adr_o),
	.wb_ack_i    (wb_ack_i),
	.pr_valid_i  (pr_valid_o),
	.mc_active_i (mc_active)
);

`default_nettype wire

/* fetch_top.sv */
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            redirect_i,
	input  wire  [pc_w-1:0]                redirect_pc_i,
	input  wire                            hwi_i,
	input  wire  [insn_w-1:0]              hwi_ins_i,
	input  wire                            mc_req_i,
	input  wire  [7:0]                     mc_entry_i,
	input  wire                            decode_ready_i,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic [adr_w-1:0]               wb_adr_o,
	input  wire  [insn_w-1:0]              wb_dat_i,
	input  wire                            wb_ack_i,
	output logic [line_w-1:0]              cline_o,
	output logic [slots-1:0]               pr_valid_o,
	output logic [slots-1:0][pc_w-1:0]     pr_pc_o,
	output logic [slots-1:0][insn_w-1:0]   pr_ins_o
);

	logic [pc_w-1:0] fetch_pc;
	logic [slots-1:0][pc_w-1:0] slot_pc;
	logic [slots-1:0] slot_mask;
	logic line_hit;
	logic [line_w-1:0] line;
	logic take_line;
	logic take_mc;
	logic mc_active;
	logic [mc_slots-1:0][insn_w-1:0] mc_ins;

	pc_gen u_pc_gen (
		.clk           (clk),
		.rst           (rst),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.take_line_i   (take_line),
		.fetch_pc_o    (fetch_pc),
		.slot_pc_o     (slot_pc),
		.slot_mask_o   (slot_mask)
	);

	line_fetch u_line_fetch (
		.clk        (clk),
		.rst        (rst),
		.fetch_pc_i (fetch_pc),
		.line_hit_o (line_hit),
		.line_o     (line),
		.wb_cyc_o   (wb_cyc_o),
		.wb_stb_o   (wb_stb_o),
		.wb_adr_o   (wb_adr_o),
		.wb_dat_i   (wb_dat_i),
		.wb_ack_i   (wb_ack_i)
	);

	mc_seq u_mc_seq (
		.clk         (clk),
		.rst         (rst),
		.mc_req_i    (mc_req_i),
		.mc_entry_i  (mc_entry_i),
		.take_mc_i   (take_mc),
		.mc_active_o (mc_active),
		.mc_ins_o    (mc_ins)
	);

	pipe_mux u_pipe_mux (
		.clk            (clk),
		.rst            (rst),
		.decode_ready_i (decode_ready_i),
		.hwi_i          (hwi_i),
		.hwi_ins_i      (hwi_ins_i),
		.mc_active_i    (mc_active),
		.mc_ins_i       (mc_ins),
		.line_hit_i     (line_hit),
		.line_i         (line),
		.slot_pc_i      (slot_pc),
		.slot_mask_i    (slot_mask),
		.take_line_o    (take_line),
		.take_mc_o      (take_mc),
		.cline_o        (cline_o),
		.pr_valid_o     (pr_valid_o),
		.pr_pc_o        (pr_pc_o),
		.pr_ins_o       (pr_ins_o)
	);

endmodule

`default_nettype wire

/* pipe_mux.sv */
`default_nettype none

module pipe_mux import fetch_pkg::*; (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                decode_ready_i,
	input  wire                                hwi_i,
	input  wire  [insn_w-1:0]                  hwi_ins_i,
	input  wire                                mc_active_i,
	input  wire  [mc_slots-1:0][insn_w-1:0]    mc_ins_i,
	input  wire                                line_hit_i,
	input  wire  [line_w-1:0]                  line_i,
	input  wire  [slots-1:0][pc_w-1:0]         slot_pc_i,
	input  wire  [slots-1:0]                   slot_mask_i,
	output logic                               take_line_o,
	output logic                               take_mc_o,
	output logic [line_w-1:0]                  cline_o,
	output logic [slots-1:0]                   pr_valid_o,
	output logic [slots-1:0][pc_w-1:0]         pr_pc_o,
	output logic [slots-1:0][insn_w-1:0]       pr_ins_o
);

	logic take_hwi;
	logic accept;
	logic [slots-1:0] valid_d;
	logic [slots-1:0][insn_w-1:0] ins_d;

	// ####################
	// Priority select

	assign take_hwi = decode_ready_i && hwi_i;
	assign take_mc_o = decode_ready_i && !hwi_i && mc_active_i;
	assign take_line_o = decode_ready_i && !hwi_i && !mc_active_i && line_hit_i;
	assign accept = take_hwi || take_mc_o || take_line_o;

	always_comb begin
		valid_d = '0;
		for (int i = 0; i < slots; i++) begin
			ins_d[i] = nop_insn; // Unused slots carry a NOP.
		end
		if (hwi_i) begin
			valid_d[0] = 1'b1;
			ins_d[0] = hwi_ins_i;
		end else if (mc_active_i) begin
			for (int i = 0; i < mc_slots; i++) begin
				valid_d[i] = 1'b1;
				ins_d[i] = mc_ins_i[i];
			end
		end else begin
			// Each slot picks its word by PC bits 5:2.
			for (int i = 0; i < slots; i++) begin
				if (slot_mask_i[i]) begin
					valid_d[i] = 1'b1;
					ins_d[i] = line_i[slot_pc_i[i][5:2]*insn_w +: insn_w];
				end
			end
		end
	end

	// ####################
	// Pipeline register

	always_ff @(posedge clk) begin
		if (rst) begin
			pr_valid_o <= '0;
		end else if (accept) begin
			pr_valid_o <= valid_d;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pr_pc_o <= slot_pc_i;
			pr_ins_o <= ins_d;
		end
		if (take_line_o) begin
			cline_o <= line_i; // Passed along for decode.
		end
	end

endmodule

`default_nettype wire

/* mc_seq.sv */
`default_nettype none

module mc_seq import fetch_pkg::*; (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                mc_req_i,
	input  wire  [7:0]                         mc_entry_i,
	input  wire                                take_mc_i,
	output logic                               mc_active_o,
	output logic [mc_slots-1:0][insn_w-1:0]    mc_ins_o
);

	mc_state_t state_q;
	logic [7:0] entry_q;
	logic [mc_step_w-1:0] step_q;

	assign mc_active_o = (state_q == MC_RUN);

	// Micro-op table, one group per step.
	always_comb begin
		for (int i = 0; i < mc_slots; i++) begin
			mc_ins_o[i] = mc_word(entry_q, 8'(step_q), 8'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= MC_IDLE;
			step_q <= '0;
		end else begin
			case (state_q)
			MC_IDLE: begin
				if (mc_req_i) begin
					state_q <= MC_RUN;
					step_q <= '0;
				end
			end
			MC_RUN: begin
				if (take_mc_i) begin
					step_q <= step_q + 1'b1;
					if (step_q == mc_step_w'(mc_len - 1)) begin
						state_q <= MC_IDLE; // Routine done.
					end
				end
			end
			default: begin
				state_q <= MC_IDLE;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == MC_IDLE && mc_req_i) begin
			entry_q <= mc_entry_i;
		end
	end

endmodule

`default_nettype wire

/* line_fetch.sv */
`default_nettype none

module line_fetch import fetch_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	input  wire  [pc_w-1:0]    fetch_pc_i,
	output logic               line_hit_o,
	output logic [line_w-1:0]  line_o,
	output logic               wb_cyc_o,
	output logic               wb_stb_o,
	output logic [adr_w-1:0]   wb_adr_o,
	input  wire  [insn_w-1:0]  wb_dat_i,
	input  wire                wb_ack_i
);

	lf_state_t state_q;
	logic tag_valid_q;
	logic [tag_w-1:0] tag_q;
	logic [word_idx_w-1:0] word_q;
	logic [line_w-1:0] line_q;
	logic miss;
	logic word_done;

	assign line_hit_o = tag_valid_q && (tag_q == fetch_pc_i[pc_w-1:6]);
	assign miss = !line_hit_o;
	assign line_o = line_q;
	assign wb_adr_o = {tag_q, word_q}; // Held stable until ack.
	assign word_done = (state_q == LF_READ) && wb_stb_o && wb_ack_i;

	// ####################
	// Refill FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= LF_IDLE;
			tag_valid_q <= 1'b0;
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			word_q <= '0;
		end else begin
			case (state_q)
			LF_IDLE: begin
				if (miss) begin
					state_q <= LF_READ;
					tag_valid_q <= 1'b0; // The line is overwritten from here on.
					wb_cyc_o <= 1'b1;
					wb_stb_o <= 1'b1;
					word_q <= '0;
				end
			end
			LF_READ: begin
				if (word_done) begin
					wb_stb_o <= 1'b0; // One idle cycle between words.
					if (word_q == '1) begin
						state_q <= LF_IDLE;
						wb_cyc_o <= 1'b0;
						tag_valid_q <= 1'b1;
					end else begin
						word_q <= word_q + 1'b1;
					end
				end else if (!wb_stb_o) begin
					wb_stb_o <= 1'b1;
				end
			end
			default: begin
				state_q <= LF_IDLE;
			end
			endcase
		end
	end

	// ####################
	// Line buffer and tag

	// The tag is taken at burst start; a later PC change is checked after the burst.
	always_ff @(posedge clk) begin
		if (state_q == LF_IDLE && miss) begin
			tag_q <= fetch_pc_i[pc_w-1:6];
		end
		if (word_done) begin
			line_q[word_q*insn_w +: insn_w] <= wb_dat_i; // Word 0 lands in bits 31:0.
		end
	end

endmodule

`default_nettype wire

/* pc_gen.sv */
`default_nettype none

module pc_gen import fetch_pkg::*; (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            redirect_i,
	input  wire  [pc_w-1:0]                redirect_pc_i,
	input  wire                            take_line_i,
	output logic [pc_w-1:0]                fetch_pc_o,
	output logic [slots-1:0][pc_w-1:0]     slot_pc_o,
	output logic [slots-1:0]               slot_mask_o
);

	logic [pc_w-1:0] pc_q;
	logic [2:0] n_slots; // Up to five slots in a bundle.

	assign fetch_pc_o = pc_q;

	// Consecutive words; a slot counts only if it stays in the line of slot 0.
	always_comb begin
		for (int i = 0; i < slots; i++) begin
			slot_pc_o[i] = pc_q + pc_w'(4 * i);
			slot_mask_o[i] = (slot_pc_o[i][pc_w-1:6] == pc_q[pc_w-1:6]);
		end
	end

	// The mask is contiguous from slot 0, so its population is the advance.
	always_comb begin
		n_slots = '0;
		for (int i = 0; i < slots; i++) begin
			n_slots = n_slots + 3'(slot_mask_o[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= '0;
		end else if (redirect_i) begin
			pc_q <= redirect_pc_i; // Redirect wins over advance.
		end else if (take_line_i) begin
			pc_q <= pc_q + pc_w'({n_slots, 2'b00});
		end
	end

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// ####################
	// Widths and counts

	localparam int insn_w = 32;
	localparam int pc_w = 32;
	localparam int line_w = 512; // Sixteen instruction words.
	localparam int slots = 5;
	localparam int mc_slots = 4;
	localparam int mc_len = 3; // Groups per microcode routine.

	localparam int mc_step_w = $clog2(mc_len);
	localparam int word_idx_w = 4; // Word index inside a 64-byte line.
	localparam int tag_w = pc_w - 6; // Line tag is PC bits 31:6.
	localparam int adr_w = pc_w - 2; // Wishbone word address.

	// ####################
	// Opcodes

	// The opcode sits in the top byte of an instruction word.
	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_MC  = 8'hf0,
		OP_HWI = 8'hf1
	} opcode_t;

	localparam logic [insn_w-1:0] nop_insn = {OP_NOP, 24'h00_0000};

	// Micro-op word: opcode, entry number, step and slot, one byte each.
	function automatic logic [insn_w-1:0] mc_word(
		input logic [7:0] entry,
		input logic [7:0] step,
		input logic [7:0] slot
	);
		return {OP_MC, entry, step, slot};
	endfunction

	// ####################
	// FSM states

	typedef enum logic {
		LF_IDLE,
		LF_READ
	} lf_state_t;

	typedef enum logic {
		MC_IDLE,
		MC_RUN
	} mc_state_t;

endpackage

`default_nettype wire
